// ==== filelist.f ====
verilog/sdProtocolPkg.sv
verilog/sdCardPkg.sv
verilog/sdCrc7.sv
verilog/sdCmdReceiver.sv
verilog/sdRespBuilder.sv
verilog/sdRespTransmitter.sv
verilog/sdCardController.sv
verilog/sdCardCmdLine.sv
verif/sdClockGen.sv
verif/sdCardTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SD command line testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module sdCardTb -o sdCardSim

output="$(./obj_dir/sdCardSim)"
echo "$output"

if grep -q "^All checks passed$" <<< "$output"; then
    exit 0
fi
exit 1

// ==== verif/sdCardTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdCardTb
    import sdProtocolPkg::*;
    import sdCardPkg::*;
();

    // Card reply to CMD55, checked before every application command
    localparam logic [5:0]  APP_CMD_INDEX = 6'd55;
    localparam logic [31:0] APP_CMD_STATUS = 32'h0000_0120;
    localparam int          RESP_WAIT = 10;

    logic     clk;
    logic     rst_;
    logic     cmdIn;
    logic     cmdOut;
    logic     cmdOe;
    logic     errorStrobe;
    errCode_e errorCode;

    string       testName [$];
    logic [6:0]  testIdx [$];
    logic [31:0] testArg [$];
    bit          testBad [$];
    logic [1:0]  testKind [$];
    logic [31:0] testResp [$];
    logic [2:0]  testErr [$];

    string      currentTest;
    int         numTests;
    int         errorCount = 0;
    int         strobeCount = 0;
    logic [2:0] lastError = 3'd0;
    bit         loaded = 1'b0;

    sdClockGen u_sdClockGen (
        .clk  (clk),
        .rst_ (rst_)
    );

    sdCardCmdLine u_sdCardCmdLine (
        .clk         (clk),
        .rst_        (rst_),
        .cmdIn       (cmdIn),
        .cmdOut      (cmdOut),
        .cmdOe       (cmdOe),
        .errorStrobe (errorStrobe),
        .errorCode   (errorCode)
    );

    always @(negedge clk) begin
        if (errorStrobe) begin
            strobeCount++;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    // x^7 + x^3 + 1, MSB first over start, direction, index and argument
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [39:0] bits;
        logic [6:0]  crc;
        logic        fb;
        bits = data;
        crc = '0;
        repeat (CRC_SPAN) begin
            fb = bits[39] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
            bits = {bits[38:0], 1'b0};
        end
        return crc;
    endfunction

    task automatic compareValue(input string what, input logic [47:0] expected,
                                input logic [47:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0s %0s: expected %0h, actual %0h",
                     currentTest, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          fields;
        string       line;
        string       name;
        logic [31:0] idx;
        logic [31:0] arg;
        logic [31:0] bad;
        logic [31:0] kind;
        logic [31:0] resp;
        logic [31:0] err;
        fd = $fopen("verif/sdCardTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file verif/sdCardTests.txt");
            errorCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h",
                                     name, idx, arg, bad, kind, resp, err);
                    if (fields == 7) begin
                        testName.push_back(name);
                        testIdx.push_back(idx[6:0]);
                        testArg.push_back(arg);
                        testBad.push_back(bad[0]);
                        testKind.push_back(kind[1:0]);
                        testResp.push_back(resp);
                        testErr.push_back(err[2:0]);
                    end
                end
            end
            $fclose(fd);
        end
        numTests = testName.size();
    endtask

    task automatic sendFrame(input logic [5:0] index, input logic [31:0] arg, input bit corrupt);
        logic [39:0] head;
        logic [6:0]  crc;
        logic [47:0] bits;
        head = {1'b0, 1'b1, index, arg};
        crc = crc7(head);
        // One flipped bit is enough
        if (corrupt) begin
            crc[3] = ~crc[3];
        end
        bits = {head, crc, 1'b1};
        repeat (FRAME_BITS) begin
            @(posedge clk);
            cmdIn <= bits[47];
            bits = {bits[46:0], 1'b0};
        end
        @(posedge clk);
        cmdIn <= 1'b1;
    endtask

    task automatic checkResponse(input string tag, input logic [5:0] expIndex,
                                 input logic [31:0] expArg, input bit isR3);
        logic [47:0] resp;
        logic [6:0]  expCrc;
        int          waited;
        int          oeCycles;
        resp = '0;
        waited = 0;
        oeCycles = 0;
        expCrc = isR3 ? 7'h7F : crc7({2'b00, expIndex, expArg});
        while (!cmdOe && waited < RESP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmdOe) begin
            $display("%0s %0s: no response started within %0d cycles",
                     currentTest, tag, RESP_WAIT);
            errorCount++;
        end else begin
            // One bit per cycle while the card drives the line
            while (cmdOe && oeCycles <= FRAME_BITS) begin
                resp = {resp[46:0], cmdOut};
                oeCycles++;
                @(negedge clk);
            end
            compareValue({tag, " oe cycles"}, 48'(FRAME_BITS), 48'(oeCycles));
            compareValue({tag, " start and dir"}, 48'd0, 48'(resp[47:46]));
            compareValue({tag, " index"}, 48'(expIndex), 48'(resp[45:40]));
            compareValue({tag, " argument"}, 48'(expArg), 48'(resp[39:8]));
            compareValue({tag, " crc"}, 48'(expCrc), 48'(resp[7:1]));
            compareValue({tag, " end bit"}, 48'd1, 48'(resp[0]));
        end
    endtask

    task automatic expectSilence(input string tag);
        bit driven;
        driven = 1'b0;
        repeat (RESP_WAIT) begin
            @(negedge clk);
            if (cmdOe) begin
                driven = 1'b1;
            end
        end
        if (driven) begin
            $display("%0s %0s: cmdOe went high although no response was expected",
                     currentTest, tag);
            errorCount++;
        end
    endtask

    task automatic runCommand(input string tag, input logic [6:0] index,
                              input logic [31:0] arg, input bit corrupt,
                              input logic [1:0] kind, input logic [31:0] respArg,
                              input logic [2:0] err);
        int strobesBefore;
        strobesBefore = strobeCount;
        sendFrame(index[5:0], arg, corrupt);
        if (kind == 2'd0) begin
            expectSilence(tag);
        end else begin
            // R3 carries index 63
            checkResponse(tag, (kind == 2'd2) ? 6'h3F : index[5:0], respArg, kind == 2'd2);
        end
        // errorCode keeps the last reported error
        if (err != 3'd0) begin
            lastError = err;
        end
        compareValue({tag, " error code"}, 48'(lastError), 48'(errorCode));
        compareValue({tag, " error strobes"}, 48'(err != 3'd0),
                     48'(strobeCount - strobesBefore));
        repeat (2) @(posedge clk);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int failsBefore;
        int testsFailed;
        testsFailed = 0;
        cmdIn <= 1'b1;
        loadTests();
        if (numTests == 0) begin
            $display("No tests were read from the test file");
            errorCount++;
        end
        loaded = 1'b1;
        wait (rst_ === 1'b1);
        repeat (2) @(posedge clk);
        for (int t = 0; t < numTests; t++) begin
            currentTest = testName[t];
            failsBefore = errorCount;
            if (testIdx[t][6]) begin
                runCommand("cmd55", {1'b0, APP_CMD_INDEX}, 32'h0, 1'b0, 2'd1,
                           APP_CMD_STATUS, 3'd0);
            end
            runCommand("cmd", testIdx[t], testArg[t], testBad[t], testKind[t],
                       testResp[t], testErr[t]);
            if (errorCount == failsBefore) begin
                $display("test %0s: ok", currentTest);
            end else begin
                $display("test %0s: failed", currentTest);
                testsFailed++;
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 numTests, numTests - testsFailed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (loaded);
        repeat (numTests * 200) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", numTests * 200);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/sdCardTests.txt ====
# name index(hex, bit 6 = ACMD) arg corrupt kind(0 none, 1 R1, 2 R3) respArg error
# error: 0 none, 1 frame, 2 rca, 3 count, 4 unknown command
cmd0Reset           00 00000000 0 0 00000000 0
cmd8Echo            08 000001AA 0 1 000001AA 0
cmd8LowBits         08 ABCD5123 0 1 00000123 0
cmd8BadCrc          08 000001AA 1 0 00000000 1
cmd7NoRca           07 AAAA0000 0 0 00000000 2
cmd3Rca             03 00000000 0 1 AAAA0520 0
cmd7Select          07 AAAA0000 0 1 00000700 0
cmd7WrongRca        07 12340000 0 0 00000000 2
acmd23Zero          57 00000000 0 0 00000000 3
acmd23Count         57 00000010 0 1 00000920 0
acmd6Width          46 00000002 0 1 00000920 0
acmd41Busy          69 40FF8000 0 2 00FF8080 0
acmd41Ready         69 40FF8000 0 2 C1FF8080 0
cmd0Idle            00 00000000 0 0 00000000 0
acmd41BusyAgain     69 40FF8000 0 2 00FF8080 0
cmd7AfterCmd0       07 AAAA0000 0 0 00000000 2
cmd9Unknown         09 00000000 0 0 00000000 4
cmd6NoPrefix        06 00000002 0 0 00000000 4
acmd41BadCrc        69 40FF8000 1 0 00000000 1
acmd41ReadyAgain    69 40FF8000 0 2 C1FF8080 0
cmd8Final           08 00000555 0 1 00000555 0

// ==== verif/sdClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdClockGen (
    output logic clk,
    output logic rst_
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held low for two rising edges
    initial begin
        rst_ <= 1'b0;
        repeat (2) @(posedge clk);
        rst_ <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/sdCardCmdLine.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdCardCmdLine
    import sdProtocolPkg::*;
    import sdCardPkg::*;
(
    input  wire logic clk,
    input  wire logic rst_,
    input  wire logic cmdIn,
    output logic      cmdOut,
    output logic      cmdOe,
    output logic      errorStrobe,
    output errCode_e  errorCode
);

    cmdFrame_t    frame;
    logic         frameOk;
    logic         frameValid;
    respContent_t content;
    respKind_e    kind;
    errCode_e     error;
    logic         acmd;
    logic [15:0]  rca;
    logic         ocrReady;
    logic         sendStart;
    respContent_t sendContent;
    logic         isR3;
    logic         sendDone;

    // ==================================================
    // Receive, decode, control, transmit
    // ==================================================
    sdCmdReceiver u_sdCmdReceiver (
        .clk        (clk),
        .rst_       (rst_),
        .cmdIn      (cmdIn),
        .frame      (frame),
        .frameOk    (frameOk),
        .frameValid (frameValid)
    );

    sdRespBuilder u_sdRespBuilder (
        .frame    (frame),
        .frameOk  (frameOk),
        .acmd     (acmd),
        .rca      (rca),
        .ocrReady (ocrReady),
        .content  (content),
        .kind     (kind),
        .error    (error)
    );

    sdCardController u_sdCardController (
        .clk         (clk),
        .rst_        (rst_),
        .frame       (frame),
        .frameValid  (frameValid),
        .content     (content),
        .kind        (kind),
        .error       (error),
        .sendDone    (sendDone),
        .acmd        (acmd),
        .rca         (rca),
        .ocrReady    (ocrReady),
        .sendStart   (sendStart),
        .sendContent (sendContent),
        .isR3        (isR3),
        .errorStrobe (errorStrobe),
        .errorCode   (errorCode)
    );

    sdRespTransmitter u_sdRespTransmitter (
        .clk       (clk),
        .rst_      (rst_),
        .sendStart (sendStart),
        .content   (sendContent),
        .isR3      (isR3),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .sendDone  (sendDone)
    );

endmodule

`default_nettype wire

// ==== verilog/sdCardController.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdCardController
    import sdProtocolPkg::*;
    import sdCardPkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_,
    input  cmdFrame_t         frame,
    input  wire logic         frameValid,
    input  respContent_t      content,
    input  respKind_e         kind,
    input  errCode_e          error,
    input  wire logic         sendDone,
    output logic              acmd,
    output logic       [15:0] rca,
    output logic              ocrReady,
    output logic              sendStart,
    output respContent_t      sendContent,
    output logic              isR3,
    output logic              errorStrobe,
    output errCode_e          errorCode
);

    ctrlState_e state;
    logic [1:0] delayCnt;
    logic [6:0] cmdIdx;
    logic       accepted;

    assign cmdIdx = {acmd, frame.index};
    assign accepted = (error == ERR_NONE);

    // ==================================================
    // Control FSM and card state
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= IDLE;
            delayCnt <= '0;
            acmd <= 1'b0;
            rca <= '0;
            ocrReady <= 1'b0;
            sendStart <= 1'b0;
            errorStrobe <= 1'b0;
            errorCode <= ERR_NONE;
        end else begin
            sendStart <= 1'b0;
            errorStrobe <= 1'b0;
            case (state)
                IDLE: begin
                    if (frameValid) begin
                        // Code only changes together with a strobe
                        if (!accepted) begin
                            errorCode <= error;
                        end
                        errorStrobe <= !accepted;
                        // Prefix lives for exactly one following frame
                        acmd <= accepted && (cmdIdx == CMD55);
                        if (accepted && (cmdIdx == CMD3)) begin
                            rca <= content.arg.rcaView.rca;
                        end
                        if (accepted && (cmdIdx == CMD0)) begin
                            rca <= '0;
                            ocrReady <= 1'b0;
                        end
                        if (accepted && (cmdIdx == ACMD41)) begin
                            ocrReady <= 1'b1;
                        end
                        if (accepted && (kind != RESP_NONE)) begin
                            delayCnt <= RESP_DELAY - 2'd1;
                            state <= TURN;
                        end
                    end
                end
                TURN: begin
                    if (delayCnt == '0) begin
                        sendStart <= 1'b1;
                        state <= SEND;
                    end else begin
                        delayCnt <= delayCnt - 2'd1;
                    end
                end
                SEND: begin
                    if (sendDone) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Response held stable for the whole transmission
    always_ff @(posedge clk) begin
        if ((state == IDLE) && frameValid) begin
            sendContent <= content;
            isR3 <= (kind == RESP_R3);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sdCardPkg.sv ====
`default_nettype none

package sdCardPkg;

    // ==================================================
    // Card constants
    // ==================================================
    localparam logic [15:0] CARD_RCA = 16'hAAAA;

    localparam logic [31:0] STATUS_TRAN = 32'h0000_0700;
    localparam logic [31:0] STATUS_APP = 32'h0000_0120;
    localparam logic [31:0] STATUS_SWITCH = 32'h0000_0920;
    // Low half of the CMD3 reply
    localparam logic [31:0] SEND_STATUS_BITS = 32'h0000_0520;

    // Power-up busy, then ready
    localparam logic [31:0] OCR_BUSY = 32'h00FF_8080;
    localparam logic [31:0] OCR_READY = 32'hC1FF_8080;

    // Cycles from decode latch to sendStart
    localparam logic [1:0] RESP_DELAY = 2'd2;

    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_FRAME,
        ERR_RCA,
        ERR_COUNT,
        ERR_CMD
    } errCode_e;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_R1,
        RESP_R3
    } respKind_e;

    typedef enum logic [1:0] {
        IDLE,
        TURN,
        SEND
    } ctrlState_e;

endpackage

`default_nettype wire

// ==== verilog/sdCmdReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdCmdReceiver
    import sdProtocolPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_,
    input  wire logic      cmdIn,
    output cmdFrame_t      frame,
    output logic           frameOk,
    output logic           frameValid
);

    logic                  busy;
    logic [5:0]            bitCnt;
    logic [FRAME_BITS-2:0] shiftReg;
    cmdFrame_t             assembled;
    logic [CRC_BITS-1:0]   crc;
    logic                  startBit;
    logic                  lastBit;
    logic                  crcEnable;

    // Line idles high, first low bit is the start bit
    assign startBit = !busy && !cmdIn;
    assign lastBit = busy && (bitCnt == 6'(FRAME_BITS - 1));
    assign crcEnable = startBit || (busy && (bitCnt < 6'(CRC_SPAN)));

    // Whole frame as seen on the edge that samples the end bit
    assign assembled = {shiftReg, cmdIn};

    sdCrc7 u_sdCrc7 (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (lastBit),
        .enable (crcEnable),
        .bitIn  (cmdIn),
        .crc    (crc)
    );

    // ==================================================
    // Bit counter and frame pulse
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            busy <= 1'b0;
            bitCnt <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= lastBit;
            if (startBit) begin
                busy <= 1'b1;
                bitCnt <= 6'd1;
            end else if (lastBit) begin
                busy <= 1'b0;
            end else if (busy) begin
                bitCnt <= bitCnt + 6'd1;
            end
        end
    end

    // Deserializer
    always_ff @(posedge clk) begin
        if (startBit || busy) begin
            shiftReg <= {shiftReg[FRAME_BITS-3:0], cmdIn};
        end
        if (lastBit) begin
            frame <= assembled;
            // End bit deliberately ignored
            frameOk <= !assembled.start && assembled.dir && (assembled.crc == crc);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sdCrc7.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdCrc7 (
    input  wire logic       clk,
    input  wire logic       rst_,
    input  wire logic       clear,
    input  wire logic       enable,
    input  wire logic       bitIn,
    output logic      [6:0] crc
);

    logic feedback;

    // x^7 + x^3 + 1, MSB first
    assign feedback = bitIn ^ crc[6];

    always_ff @(posedge clk) begin
        if (!rst_ || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sdProtocolPkg.sv ====
`default_nettype none

package sdProtocolPkg;

    // ==================================================
    // Frame geometry
    // ==================================================
    localparam int FRAME_BITS = 48;
    localparam int CRC_BITS = 7;
    // Start, direction, index and argument
    localparam int CRC_SPAN = 40;

    // Prefix flag over the 6-bit index
    localparam logic [6:0] CMD0 = {1'b0, 6'd0};
    localparam logic [6:0] CMD3 = {1'b0, 6'd3};
    localparam logic [6:0] CMD7 = {1'b0, 6'd7};
    localparam logic [6:0] CMD8 = {1'b0, 6'd8};
    localparam logic [6:0] CMD55 = {1'b0, 6'd55};
    localparam logic [6:0] ACMD6 = {1'b1, 6'd6};
    localparam logic [6:0] ACMD23 = {1'b1, 6'd23};
    localparam logic [6:0] ACMD41 = {1'b1, 6'd41};

    // ==================================================
    // Argument views
    // ==================================================
    typedef struct packed {
        logic [15:0] rca;
        logic [15:0] stuff;
    } rcaArg_t;

    typedef struct packed {
        logic [8:0]  reserved;
        logic [22:0] count;
    } countArg_t;

    typedef union packed {
        rcaArg_t   rcaView;
        countArg_t countView;
    } cmdArg_u;

    // Host command, MSB is the start bit
    typedef struct packed {
        logic                start;
        logic                dir;
        logic [5:0]          index;
        cmdArg_u             arg;
        logic [CRC_BITS-1:0] crc;
        logic                stop;
    } cmdFrame_t;

    // Index and argument of a response, CRC is added on the wire
    typedef struct packed {
        logic [5:0] index;
        cmdArg_u    arg;
    } respContent_t;

endpackage

`default_nettype wire

// ==== verilog/sdRespBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdRespBuilder
    import sdProtocolPkg::*;
    import sdCardPkg::*;
(
    input  cmdFrame_t         frame,
    input  wire logic         frameOk,
    input  wire logic         acmd,
    input  wire logic  [15:0] rca,
    input  wire logic         ocrReady,
    output respContent_t      content,
    output respKind_e         kind,
    output errCode_e          error
);

    logic [6:0]  cmdIdx;
    logic [31:0] argWord;

    assign cmdIdx = {acmd, frame.index};
    assign argWord = frame.arg;

    always_comb begin
        content.index = frame.index;
        content.arg = '0;
        kind = RESP_R1;
        error = ERR_NONE;

        case (cmdIdx)
            CMD0: begin
                kind = RESP_NONE;
            end
            CMD3: begin
                content.arg = {CARD_RCA, 16'h0000} | SEND_STATUS_BITS;
            end
            CMD7: begin
                if (frame.arg.rcaView.rca != rca) begin
                    error = ERR_RCA;
                end
                content.arg = STATUS_TRAN;
            end
            CMD8: begin
                // Voltage and check pattern come back unchanged
                content.arg = {20'h00000, argWord[11:0]};
            end
            CMD55: begin
                content.arg = STATUS_APP;
            end
            ACMD6: begin
                content.arg = STATUS_SWITCH;
            end
            ACMD23: begin
                if (frame.arg.countView.count == '0) begin
                    error = ERR_COUNT;
                end
                content.arg = STATUS_SWITCH;
            end
            ACMD41: begin
                // R3 carries index 63 and no real CRC
                kind = RESP_R3;
                content.index = 6'h3F;
                content.arg = ocrReady ? OCR_READY : OCR_BUSY;
            end
            default: begin
                error = ERR_CMD;
            end
        endcase

        // Frame faults override any decode
        if (!frameOk) begin
            error = ERR_FRAME;
        end
        if (error != ERR_NONE) begin
            kind = RESP_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sdRespTransmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdRespTransmitter
    import sdProtocolPkg::*;
    import sdCardPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_,
    input  wire logic    sendStart,
    input  respContent_t content,
    input  wire logic    isR3,
    output logic         cmdOut,
    output logic         cmdOe,
    output logic         sendDone
);

    logic                busy;
    logic [5:0]          bitCnt;
    logic [CRC_SPAN-2:0] txReg;
    logic [CRC_BITS-1:0] crc;
    logic [5:0]          crcSel;
    logic                loadStart;
    logic                lastCycle;
    logic                crcEnable;
    logic                crcBit;
    logic                nextBit;

    assign loadStart = sendStart && !busy;
    assign lastCycle = busy && (bitCnt == 6'(FRAME_BITS));
    assign crcEnable = loadStart || (busy && (bitCnt < 6'(CRC_SPAN)));
    // Start bit on the load edge, then the shifted payload
    assign crcBit = busy ? txReg[CRC_SPAN-2] : 1'b0;

    // Bit 40 carries crc[6], bit 46 carries crc[0]
    assign crcSel = 6'(FRAME_BITS - 2) - bitCnt;

    sdCrc7 u_sdCrc7 (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (lastCycle),
        .enable (crcEnable),
        .bitIn  (crcBit),
        .crc    (crc)
    );

    always_comb begin
        if (bitCnt < 6'(CRC_SPAN)) begin
            nextBit = txReg[CRC_SPAN-2];
        end else if (bitCnt < 6'(FRAME_BITS - 1)) begin
            nextBit = isR3 ? 1'b1 : crc[crcSel[2:0]];
        end else begin
            nextBit = 1'b1;
        end
    end

    // ==================================================
    // Line driver
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            busy <= 1'b0;
            bitCnt <= '0;
            cmdOut <= 1'b1;
            cmdOe <= 1'b0;
            sendDone <= 1'b0;
        end else begin
            sendDone <= 1'b0;
            if (loadStart) begin
                busy <= 1'b1;
                bitCnt <= 6'd1;
                cmdOut <= 1'b0;
                cmdOe <= 1'b1;
            end else if (lastCycle) begin
                busy <= 1'b0;
                cmdOut <= 1'b1;
                cmdOe <= 1'b0;
                sendDone <= 1'b1;
            end else if (busy) begin
                cmdOut <= nextBit;
                bitCnt <= bitCnt + 6'd1;
            end
        end
    end

    // Direction bit is 0 for a card response
    always_ff @(posedge clk) begin
        if (loadStart) begin
            txReg <= {1'b0, content.index, content.arg};
        end else if (busy) begin
            txReg <= {txReg[CRC_SPAN-3:0], 1'b0};
        end
    end

endmodule

`default_nettype wire
